// File: Bender.yml
package:
  name: orange_tracker

sources:
  - common/vision_pkg.sv
  - hw/pixel_capture.sv
  - hw/orange_classifier.sv
  - zone_classification/zone_accumulator.sv
  - zone_classification/direction_decider.sv
  - hw/orange_tracker_top.sv
  - target: simulation
    files:
      - verif/tracker_checker.sv
      - verif/tb_orange_tracker.sv

// File: build.f
common/vision_pkg.sv
hw/pixel_capture.sv
hw/orange_classifier.sv
zone_classification/zone_accumulator.sv
zone_classification/direction_decider.sv
hw/orange_tracker_top.sv
verif/tracker_checker.sv
verif/tb_orange_tracker.sv

// File: common/vision_pkg.sv
package vision_pkg;

    // Channel and counter widths
    localparam int color_w = 4;   // RGB444, one nibble per channel
    localparam int count_w = 18;  // Enough for a full 320x240 frame

    // Orange colour window, applied per channel
    localparam logic [color_w-1:0] orange_red_min   = 4'd12;
    localparam logic [color_w-1:0] orange_green_min = 4'd4;
    localparam logic [color_w-1:0] orange_green_max = 4'd9;
    localparam logic [color_w-1:0] orange_blue_max  = 4'd4;

    // Direction reported at the end of each frame
    typedef enum logic [2:0] {
        dir_none   = 3'b000,
        dir_left   = 3'b001,
        dir_right  = 3'b010,
        dir_center = 3'b011
    } dir_t;

endpackage

// File: hw/orange_classifier.sv
`timescale 1ns/1ps

module orange_classifier import vision_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pix_valid,
    input  logic [color_w-1:0] red,
    input  logic [color_w-1:0] green,
    input  logic [color_w-1:0] blue,
    output logic               orange_valid,
    output logic               is_orange
);

    logic red_ok;
    logic green_ok;
    logic blue_ok;
    logic match;

    // Per-channel window checks
    always_comb begin
        red_ok   = (red >= orange_red_min);
        green_ok = (green >= orange_green_min) && (green <= orange_green_max);
        blue_ok  = (blue <= orange_blue_max);
        match    = red_ok && green_ok && blue_ok;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            orange_valid <= 1'b0;
            is_orange    <= 1'b0;
        end else begin
            orange_valid <= pix_valid;  // One cycle behind the pixel
            if (pix_valid) begin
                is_orange <= match;
            end
        end
    end

endmodule

// File: hw/orange_tracker_top.sv
`timescale 1ns/1ps

module orange_tracker_top import vision_pkg::*; #(
    parameter int img_width        = 320,
    parameter int img_height       = 240,
    parameter int left_end         = 70,
    parameter int right_start      = 290,
    parameter int threshold_pixels = 768
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               href,
    input  logic [7:0]         cam_data,
    output logic               orange_detected,
    output dir_t               direction,
    output logic [count_w-1:0] orange_count,
    output logic               frame_valid
);

    logic               pix_valid;
    logic [color_w-1:0] red;
    logic [color_w-1:0] green;
    logic [color_w-1:0] blue;
    logic               orange_valid;
    logic               is_orange;
    logic               frame_done;
    logic [count_w-1:0] count_left;
    logic [count_w-1:0] count_center;
    logic [count_w-1:0] count_right;
    logic [count_w-1:0] count_total;

    // Byte pairing
    pixel_capture u_capture (
        .clk       (clk),
        .rst_n     (rst_n),
        .href      (href),
        .cam_data  (cam_data),
        .pix_valid (pix_valid),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

    orange_classifier u_classifier (
        .clk          (clk),
        .rst_n        (rst_n),
        .pix_valid    (pix_valid),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .orange_valid (orange_valid),
        .is_orange    (is_orange)
    );

    zone_accumulator #(
        .img_width   (img_width),
        .img_height  (img_height),
        .left_end    (left_end),
        .right_start (right_start)
    ) u_accumulator (
        .clk          (clk),
        .rst_n        (rst_n),
        .orange_valid (orange_valid),
        .is_orange    (is_orange),
        .frame_done   (frame_done),
        .count_left   (count_left),
        .count_center (count_center),
        .count_right  (count_right),
        .count_total  (count_total)
    );

    // Frame decision and outputs
    direction_decider #(
        .threshold_pixels (threshold_pixels)
    ) u_decider (
        .clk             (clk),
        .rst_n           (rst_n),
        .frame_done      (frame_done),
        .count_left      (count_left),
        .count_center    (count_center),
        .count_right     (count_right),
        .count_total     (count_total),
        .orange_detected (orange_detected),
        .direction       (direction),
        .orange_count    (orange_count),
        .frame_valid     (frame_valid)
    );

endmodule

// File: hw/pixel_capture.sv
`timescale 1ns/1ps

module pixel_capture import vision_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               href,
    input  logic [7:0]         cam_data,
    output logic               pix_valid,
    output logic [color_w-1:0] red,
    output logic [color_w-1:0] green,
    output logic [color_w-1:0] blue
);

    logic               href_q;      // Registered href
    logic [7:0]         data_q;      // Registered camera byte
    logic               byte_phase;  // 0 first byte, 1 second byte
    logic [color_w-1:0] red_hold;    // Red nibble of the first byte

    // Input stage and byte phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            href_q     <= 1'b0;
            byte_phase <= 1'b0;
            pix_valid  <= 1'b0;
        end else begin
            href_q    <= href;
            pix_valid <= 1'b0;
            if (href_q) begin
                byte_phase <= ~byte_phase;
                if (byte_phase) begin
                    pix_valid <= 1'b1;  // Second byte completes the pixel
                end
            end else begin
                byte_phase <= 1'b0;     // Drops any half pixel
            end
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        data_q <= cam_data;
        if (href_q && !byte_phase) begin
            red_hold <= data_q[3:0];
        end
        if (href_q && byte_phase) begin
            red   <= red_hold;
            green <= data_q[7:4];
            blue  <= data_q[3:0];
        end
    end

endmodule

// File: verif/tb_orange_tracker.sv
`timescale 1ns/1ps

module tb_orange_tracker import vision_pkg::*; ();

    localparam int n_frames    = 6;
    localparam int width       = 16;
    localparam int height      = 4;
    localparam int left_end    = 4;
    localparam int right_start = 12;
    localparam int wait_limit  = 200;

    logic               clk;
    logic               rst_n;
    logic               href;
    logic [7:0]         cam_data;
    logic               orange_detected;
    dir_t               direction;
    logic [count_w-1:0] orange_count;
    logic               frame_valid;

    // Frame table with zone counts per orange row
    int   tab_rows [0:n_frames-1];
    int   tab_left [0:n_frames-1];
    int   tab_center [0:n_frames-1];
    int   tab_right [0:n_frames-1];
    bit   tab_stray [0:n_frames-1];
    logic tab_det [0:n_frames-1];
    dir_t tab_dir [0:n_frames-1];
    int   tab_total [0:n_frames-1];

    logic [7:0] lfsr = 8'd27;
    int         timeouts = 0;

    orange_tracker_top #(
        .img_width        (width),
        .img_height       (height),
        .left_end         (left_end),
        .right_start      (right_start),
        .threshold_pixels (6)
    ) UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .href            (href),
        .cam_data        (cam_data),
        .orange_detected (orange_detected),
        .direction       (direction),
        .orange_count    (orange_count),
        .frame_valid     (frame_valid)
    );

    tracker_checker u_checker (
        .clk             (clk),
        .rst_n           (rst_n),
        .orange_detected (orange_detected),
        .direction       (direction),
        .orange_count    (orange_count),
        .frame_valid     (frame_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Taps 8, 6, 5, 4
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task take_random_bits(input int n, output logic [11:0] val);
        val = '0;
        repeat (n) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[10:0], lfsr[0]};
        end
    endtask

    function automatic bit colour_is_orange(input logic [11:0] rgb);
        return rgb[11:8] >= 4'd12 && rgb[7:4] >= 4'd4 && rgb[7:4] <= 4'd9 && rgb[3:0] <= 4'd4;
    endfunction

    task set_frame(input int idx, input int rows, input int nl, input int nc, input int nr,
                   input bit stray, input logic det, input dir_t dir, input int total);
        tab_rows[idx]   = rows;
        tab_left[idx]   = nl;
        tab_center[idx] = nc;
        tab_right[idx]  = nr;
        tab_stray[idx]  = stray;
        tab_det[idx]    = det;
        tab_dir[idx]    = dir;
        tab_total[idx]  = total;
    endtask

    task drive_byte(input logic [7:0] b);
        @(posedge clk);
        #1;
        href     = 1'b1;
        cam_data = b;
    endtask

    // Odd columns get a random colour that is not orange
    task pick_background(input int col, output logic [11:0] rgb);
        int tries;
        rgb = 12'h333;
        if (col % 2 == 1) begin
            take_random_bits(12, rgb);
            for (tries = 0; tries < 8 && colour_is_orange(rgb); tries++) begin
                take_random_bits(12, rgb);
            end
            if (colour_is_orange(rgb)) rgb = 12'h333;
        end
    endtask

    task send_row(input int nl, input int nc, input int nr, input bit stray, input bit last);
        int          col;
        bit          orange;
        logic [11:0] rgb;
        for (col = 0; col < width; col++) begin
            if (col < left_end) orange = col < nl;
            else if (col < right_start) orange = col - left_end < nc;
            else orange = col - right_start < nr;
            if (orange) rgb = 12'hF62;
            else pick_background(col, rgb);
            drive_byte({4'hA, rgb[11:8]});  // High nibble is ignored
            drive_byte(rgb[7:0]);
        end
        @(posedge clk);
        if (last) u_checker.note_last_take();
        #1;
        if (stray) begin
            cam_data = 8'h5F;  // Half pixel that is dropped with href
            @(posedge clk);
            #1;
        end
        href     = 1'b0;
        cam_data = 8'h00;
        repeat (2) begin
            @(posedge clk);
            #1;
        end
    endtask

    task wait_frame_valid(output bit seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < wait_limit) begin
            @(negedge clk);
            n++;
            seen = frame_valid;
        end
    endtask

    initial begin
        int frame;
        int row;
        int errors;
        bit seen;
        href     = 1'b0;
        cam_data = 8'h00;
        rst_n    = 1'b0;
        set_frame(0, 4, 1, 2, 4, 1'b0, 1'b1, dir_right, 28);
        set_frame(1, 4, 1, 6, 1, 1'b0, 1'b1, dir_center, 32);
        set_frame(2, 4, 4, 2, 1, 1'b1, 1'b1, dir_left, 28);
        set_frame(3, 2, 0, 1, 2, 1'b0, 1'b0, dir_left, 6);     // At threshold so left holds
        set_frame(4, 1, 1, 5, 1, 1'b0, 1'b1, dir_center, 7);
        set_frame(5, 4, 3, 1, 3, 1'b1, 1'b1, dir_center, 28);  // Left/right tie holds center
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (2) @(posedge clk);
        frame = 0;
        while (frame < n_frames && timeouts == 0) begin
            u_checker.push_expected(tab_det[frame], tab_dir[frame], tab_total[frame]);
            for (row = 0; row < height; row++) begin
                if (row < tab_rows[frame]) begin
                    send_row(tab_left[frame], tab_center[frame], tab_right[frame],
                             tab_stray[frame], row == height - 1);
                end else begin
                    send_row(0, 0, 0, tab_stray[frame], row == height - 1);
                end
            end
            wait_frame_valid(seen);
            if (!seen) begin
                timeouts++;
                $display("timeout: no frame_valid within %0d cycles for frame %0d",
                         wait_limit, frame);
            end
            frame++;
        end
        @(negedge clk);
        errors = u_checker.error_count + timeouts;
        $display("checks %0d, errors %0d, timeouts %0d", u_checker.check_count,
                 u_checker.error_count, timeouts);
        if (errors == 0 && u_checker.check_count > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verif/tracker_checker.sv
`timescale 1ns/1ps

module tracker_checker import vision_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               orange_detected,
    input  dir_t               direction,
    input  logic [count_w-1:0] orange_count,
    input  logic               frame_valid
);

    localparam int max_frames = 16;

    logic exp_det [0:max_frames-1];
    dir_t exp_dir [0:max_frames-1];
    int   exp_total [0:max_frames-1];
    int   wr_idx = 0;
    int   rd_idx = 0;
    int   error_count = 0;
    int   check_count = 0;
    time  take_time = 0;      // Edge that took the last second byte
    logic reset_checked = 1'b0;
    logic fv_q = 1'b0;

    task push_expected(input logic det, input dir_t dir, input int total);
        exp_det[wr_idx]   = det;
        exp_dir[wr_idx]   = dir;
        exp_total[wr_idx] = total;
        wr_idx++;
    endtask

    task note_last_take();
        take_time = $time;
    endtask

    task compare(input string what, input logic [31:0] got, input logic [31:0] want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && !reset_checked) begin
            compare("orange_detected after reset", orange_detected, 0);
            compare("direction after reset", direction, dir_none);
            compare("orange_count after reset", orange_count, 0);
            reset_checked = 1'b1;
        end
        if (rst_n && frame_valid && fv_q) begin
            error_count++;
            $display("frame_valid stayed high for more than one cycle at %0t ns", $time);
        end else if (rst_n && frame_valid) begin
            if (rd_idx == wr_idx) begin
                error_count++;
                $display("frame_valid at %0t ns with no frame expected", $time);
            end else begin
                compare($sformatf("frame %0d orange_detected", rd_idx), orange_detected,
                        exp_det[rd_idx]);
                compare($sformatf("frame %0d direction", rd_idx), direction, exp_dir[rd_idx]);
                compare($sformatf("frame %0d orange_count", rd_idx), orange_count,
                        exp_total[rd_idx]);
                // Half a cycle past the rising edge, so strip 5 ns before dividing
                compare($sformatf("frame %0d latency in cycles", rd_idx),
                        int'((($time - take_time) - 5) / 10), 4);
                rd_idx++;
            end
        end
        fv_q = frame_valid;
    end

endmodule

// File: zone_classification/direction_decider.sv
`timescale 1ns/1ps

module direction_decider import vision_pkg::*; #(
    parameter int threshold_pixels = 768
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               frame_done,
    input  logic [count_w-1:0] count_left,
    input  logic [count_w-1:0] count_center,
    input  logic [count_w-1:0] count_right,
    input  logic [count_w-1:0] count_total,
    output logic               orange_detected,
    output dir_t               direction,
    output logic [count_w-1:0] orange_count,
    output logic               frame_valid
);

    logic detected;

    // Strictly above the threshold counts as a detection
    assign detected = count_total > count_w'(threshold_pixels);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            orange_detected <= 1'b0;
            direction       <= dir_none;
            orange_count    <= '0;
            frame_valid     <= 1'b0;
        end else begin
            frame_valid <= frame_done;
            if (frame_done) begin
                orange_count    <= count_total;
                orange_detected <= detected;
                if (detected) begin
                    // Priority right, center, left; a tie keeps the old value
                    if (count_right > count_left) begin
                        direction <= dir_right;
                    end else if (count_center > count_left && count_center > count_right) begin
                        direction <= dir_center;
                    end else if (count_left > count_right) begin
                        direction <= dir_left;
                    end
                end
            end
        end
    end

endmodule

// File: zone_classification/zone_accumulator.sv
`timescale 1ns/1ps

module zone_accumulator import vision_pkg::*; #(
    parameter int img_width   = 320,
    parameter int img_height  = 240,
    parameter int left_end    = 70,
    parameter int right_start = 290
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               orange_valid,
    input  logic               is_orange,
    output logic               frame_done,
    output logic [count_w-1:0] count_left,
    output logic [count_w-1:0] count_center,
    output logic [count_w-1:0] count_right,
    output logic [count_w-1:0] count_total
);

    localparam int col_w = (img_width > 1) ? $clog2(img_width) : 1;
    localparam int row_w = (img_height > 1) ? $clog2(img_height) : 1;

    logic [col_w-1:0]   col_cnt;
    logic [row_w-1:0]   row_cnt;
    logic [count_w-1:0] run_left;
    logic [count_w-1:0] run_center;
    logic [count_w-1:0] run_right;
    logic [count_w-1:0] run_total;

    logic               in_left;
    logic               in_right;
    logic               in_center;
    logic               row_end;
    logic               frame_end;
    logic [count_w-1:0] next_left;
    logic [count_w-1:0] next_center;
    logic [count_w-1:0] next_right;
    logic [count_w-1:0] next_total;

    // Zone of the current column and running sums including this pixel
    always_comb begin
        in_left     = int'(col_cnt) < left_end;
        in_right    = int'(col_cnt) >= right_start;
        in_center   = !in_left && !in_right;
        row_end     = int'(col_cnt) == img_width - 1;
        frame_end   = row_end && (int'(row_cnt) == img_height - 1);
        next_left   = run_left + count_w'(is_orange && in_left);
        next_center = run_center + count_w'(is_orange && in_center);
        next_right  = run_right + count_w'(is_orange && in_right);
        next_total  = run_total + count_w'(is_orange);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt      <= '0;
            row_cnt      <= '0;
            run_left     <= '0;
            run_center   <= '0;
            run_right    <= '0;
            run_total    <= '0;
            frame_done   <= 1'b0;
            count_left   <= '0;
            count_center <= '0;
            count_right  <= '0;
            count_total  <= '0;
        end else begin
            frame_done <= orange_valid && frame_end;
            if (orange_valid) begin
                // Column and row position
                if (row_end) begin
                    col_cnt <= '0;
                    row_cnt <= frame_end ? '0 : row_cnt + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end

                if (frame_end) begin
                    count_left   <= next_left;    // Last pixel included
                    count_center <= next_center;
                    count_right  <= next_right;
                    count_total  <= next_total;
                    run_left     <= '0;
                    run_center   <= '0;
                    run_right    <= '0;
                    run_total    <= '0;
                end else begin
                    run_left   <= next_left;
                    run_center <= next_center;
                    run_right  <= next_right;
                    run_total  <= next_total;
                end
            end
        end
    end

endmodule
